//--- source/mu_regs_pkg.sv
package mu_regs_pkg;

	////////////////////////////////////////////////////////////
	// bus geometry
	////////////////////////////////////////////////////////////
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W = WB_DATA_W / 8;
	// word index sits in adr[4:2]
	localparam int REG_ADDR_W = 3;
	localparam int REG_ADDR_LSB = 2;

	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////
	localparam reg_addr_t REG_DELTA = 3'd0;
	localparam reg_addr_t REG_CTL = 3'd1;
	localparam reg_addr_t REG_THRESHOLD = 3'd2;
	localparam reg_addr_t REG_POINT = 3'd3;

	// delta register, threshold step low, delay step above it
	localparam int THR_DELTA_LSB = 0;
	localparam int DLY_DELTA_LSB = 16;
	localparam int CTL_RUN_BIT = 0;
	localparam int CTL_BUSY_BIT = 1;
	localparam int DIRECT_THR_LSB = 0;
	localparam int THR_RDY1_BIT = 0;
	localparam int THR_RDY2_BIT = 1;
	// point word is {channel, delay code, threshold, valid}
	localparam int POINT_VALID_BIT = 0;
	localparam int POINT_DATA_LSB = 1;

endpackage

//--- source/mu_meas_pkg.sv
package mu_meas_pkg;

	////////////////////////////////////////////////////////////
	// measurement widths
	////////////////////////////////////////////////////////////
	localparam int THRESHOLD_W = 16;
	localparam int DELAY_CODE_W = 10;
	// dac frame is zero padding then the code
	localparam int DAC_FRAME_W = 24;
	localparam int DAC_PAD_W = DAC_FRAME_W - THRESHOLD_W;

	typedef logic [THRESHOLD_W-1:0] threshold_t;
	typedef logic [DELAY_CODE_W-1:0] delay_code_t;

	// one measured point, channel tag on top
	typedef struct packed {
		logic channel;
		delay_code_t delay_code;
		threshold_t threshold;
	} point_t;

	// per-channel scan sequence
	typedef enum logic [2:0] {
		scan_idle,
		scan_load,
		scan_wait_dac,
		scan_sample,
		scan_emit,
		scan_done
	} scan_state_t;

endpackage

//--- source/mu_ctl_if.sv
`timescale 1ns/1ps

interface mu_ctl_if;
	import mu_meas_pkg::*;

	// scan enable, shared by both channels
	logic run;
	// step sizes
	threshold_t threshold_delta;
	delay_code_t delay_delta;
	// direct dac write, one-cycle strobe
	threshold_t direct_code;
	logic direct_wre;

	modport regs (
		output run, threshold_delta, delay_delta, direct_code, direct_wre
	);

	modport scan (
		input run, threshold_delta, delay_delta, direct_code, direct_wre
	);

endinterface

//--- source/mu_wb_regs.sv
`timescale 1ns/1ps

module mu_wb_regs #(
	parameter mu_meas_pkg::delay_code_t DEFAULT_DELAY_DELTA = 10'd1,
	parameter mu_meas_pkg::threshold_t DEFAULT_THRESHOLD_DELTA = 16'd1
) (
	input	logic				wb_clk_i,
	input	logic				wb_rst_i,
	input	mu_regs_pkg::wb_data_t		wb_dat_i,
	input	mu_regs_pkg::wb_data_t		wb_adr_i,
	input	logic				wb_we_i,
	input	logic [mu_regs_pkg::WB_SEL_W-1:0]	wb_sel_i,
	input	logic				wb_cyc_i,
	input	logic				wb_stb_i,
	output	mu_regs_pkg::wb_data_t		wb_dat_o,
	output	logic				wb_ack_o,
	mu_ctl_if.regs				ctl,
	input	logic [1:0]			scan_busy_i,
	input	logic [1:0]			dac_rdy_i,
	input	mu_meas_pkg::point_t		fifo_head_i,
	input	logic				fifo_n_empty_i,
	output	logic				fifo_pop_o
);
	import mu_regs_pkg::*;
	import mu_meas_pkg::*;

	reg_addr_t addr;
	logic wb_req;
	logic wb_acc;
	logic wr_delta;
	logic wr_ctl;
	logic wr_thr;
	logic rd_point;
	logic any_busy;
	// set once a started scan has shown busy
	logic scan_seen;
	wb_data_t cur_word;
	wb_data_t merged_word;
	wb_data_t rd_word;

	////////////////////////////////////////////////////////////
	// cycle decode
	////////////////////////////////////////////////////////////
	assign addr = wb_adr_i[REG_ADDR_LSB +: REG_ADDR_W];
	assign wb_req = wb_cyc_i & wb_stb_i;
	// no access in the cycle right after ack
	assign wb_acc = wb_req & ~wb_ack_o;
	assign wr_delta = wb_acc & wb_we_i & (addr == REG_DELTA);
	assign wr_ctl = wb_acc & wb_we_i & (addr == REG_CTL);
	assign wr_thr = wb_acc & wb_we_i & (addr == REG_THRESHOLD);
	assign rd_point = wb_acc & ~wb_we_i & (addr == REG_POINT);
	// empty fifo reads give valid 0 and pop nothing
	assign fifo_pop_o = rd_point & fifo_n_empty_i;
	assign any_busy = |scan_busy_i;

	// current value of the addressed register
	always_comb begin
		cur_word = '0;
		case (addr)
			REG_DELTA: begin
				cur_word[THR_DELTA_LSB +: THRESHOLD_W] = ctl.threshold_delta;
				cur_word[DLY_DELTA_LSB +: DELAY_CODE_W] = ctl.delay_delta;
			end
			REG_CTL: begin
				cur_word[CTL_RUN_BIT] = ctl.run;
				cur_word[CTL_BUSY_BIT] = any_busy;
			end
			REG_THRESHOLD: begin
				cur_word[DIRECT_THR_LSB +: THRESHOLD_W] = ctl.direct_code;
			end
			default: begin
				cur_word = '0;
			end
		endcase
	end

	// byte lanes not selected keep their old value
	always_comb begin
		for (int b = 0; b < WB_SEL_W; b++) begin
			merged_word[8*b +: 8] = wb_sel_i[b] ? wb_dat_i[8*b +: 8] : cur_word[8*b +: 8];
		end
	end

	// read mux
	always_comb begin
		rd_word = '0;
		case (addr)
			REG_DELTA, REG_CTL: begin
				rd_word = cur_word;
			end
			REG_THRESHOLD: begin
				rd_word[THR_RDY1_BIT] = dac_rdy_i[0];
				rd_word[THR_RDY2_BIT] = dac_rdy_i[1];
			end
			REG_POINT: begin
				if (fifo_n_empty_i) begin
					rd_word[POINT_VALID_BIT] = 1'b1;
					rd_word[POINT_DATA_LSB +: $bits(point_t)] = fifo_head_i;
				end
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// ack and read data
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_acc;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_acc) begin
			wb_dat_o <= rd_word;
		end
	end

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ctl.threshold_delta <= DEFAULT_THRESHOLD_DELTA;
			ctl.delay_delta <= DEFAULT_DELAY_DELTA;
		end else if (wr_delta) begin
			ctl.threshold_delta <= merged_word[THR_DELTA_LSB +: THRESHOLD_W];
			ctl.delay_delta <= merged_word[DLY_DELTA_LSB +: DELAY_CODE_W];
		end
	end

	// run drops by itself once both channels have finished
	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ctl.run <= 1'b0;
			scan_seen <= 1'b0;
		end else if (wr_ctl) begin
			ctl.run <= merged_word[CTL_RUN_BIT];
			scan_seen <= 1'b0;
		end else if (ctl.run && scan_seen && !any_busy) begin
			ctl.run <= 1'b0;
			scan_seen <= 1'b0;
		end else if (ctl.run && any_busy) begin
			scan_seen <= 1'b1;
		end
	end

	// direct threshold, strobe lasts one cycle
	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			ctl.direct_code <= '0;
			ctl.direct_wre <= 1'b0;
		end else begin
			ctl.direct_wre <= wr_thr;
			if (wr_thr) begin
				ctl.direct_code <= merged_word[DIRECT_THR_LSB +: THRESHOLD_W];
			end
		end
	end

endmodule

//--- source/threshold_scan.sv
`timescale 1ns/1ps

module threshold_scan #(
	parameter logic CHANNEL = 1'b0
) (
	input	logic				wb_clk_i,
	input	logic				wb_rst_i,
	mu_ctl_if.scan				ctl,
	input	logic				cmp_i,
	output	mu_meas_pkg::threshold_t	dac_code_o,
	output	logic				dac_wre_o,
	input	logic				dac_rdy_i,
	output	mu_meas_pkg::delay_code_t	delay_code_o,
	output	mu_meas_pkg::point_t		point_o,
	output	logic				point_valid_o,
	input	logic				point_accept_i,
	output	logic				busy_o
);
	import mu_meas_pkg::*;

	scan_state_t state;
	threshold_t threshold;
	delay_code_t delay_code;
	// one extra bit catches the carry
	logic [THRESHOLD_W:0] threshold_sum;
	logic [DELAY_CODE_W:0] delay_sum;

	assign threshold_sum = {1'b0, threshold} + {1'b0, ctl.threshold_delta};
	assign delay_sum = {1'b0, delay_code} + {1'b0, ctl.delay_delta};

	////////////////////////////////////////////////////////////
	// dac side
	////////////////////////////////////////////////////////////
	// idle forwards software writes, otherwise the scan threshold
	assign dac_code_o = (state == scan_idle) ? ctl.direct_code : threshold;
	assign dac_wre_o = dac_rdy_i & (((state == scan_idle) & ctl.direct_wre & ~ctl.run) |
		(state == scan_load));

	assign delay_code_o = delay_code;
	assign point_o = '{channel: CHANNEL, delay_code: delay_code, threshold: threshold};
	assign point_valid_o = (state == scan_emit);
	assign busy_o = (state == scan_load) | (state == scan_wait_dac) |
		(state == scan_sample) | (state == scan_emit);

	////////////////////////////////////////////////////////////
	// scan fsm
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state <= scan_idle;
			threshold <= '0;
			delay_code <= '0;
		end else if (!ctl.run) begin
			// clearing run aborts or releases done
			state <= scan_idle;
		end else begin
			case (state)
				scan_idle: begin
					threshold <= '0;
					delay_code <= '0;
					state <= scan_load;
				end
				// write goes out once the dac is free
				scan_load: begin
					if (dac_rdy_i) begin
						state <= scan_wait_dac;
					end
				end
				scan_wait_dac: begin
					if (dac_rdy_i) begin
						state <= scan_sample;
					end
				end
				// comparator low or top reached gives a point
				scan_sample: begin
					if (!cmp_i || threshold_sum[THRESHOLD_W]) begin
						state <= scan_emit;
					end else begin
						threshold <= threshold_sum[THRESHOLD_W-1:0];
						state <= scan_load;
					end
				end
				// held until the fifo takes it
				scan_emit: begin
					if (point_accept_i) begin
						if (delay_sum[DELAY_CODE_W]) begin
							state <= scan_done;
						end else begin
							delay_code <= delay_sum[DELAY_CODE_W-1:0];
							threshold <= '0;
							state <= scan_load;
						end
					end
				end
				default: begin
					state <= scan_done;
				end
			endcase
		end
	end

endmodule

//--- source/dac_spi_master.sv
`timescale 1ns/1ps

module dac_spi_master #(
	parameter int CLK_DIV = 3,
	parameter int WAIT_CYCLES = 3
) (
	input	logic				wb_clk_i,
	input	logic				wb_rst_i,
	input	mu_meas_pkg::threshold_t	code_i,
	input	logic				wre_i,
	output	logic				rdy_o,
	output	logic				sync_o,
	output	logic				sclk_o,
	output	logic				sdi_o
);
	import mu_meas_pkg::*;

	// one bit spans 2*CLK_DIV clocks
	localparam int DIV_W = $clog2(2 * CLK_DIV);
	localparam int BIT_W = $clog2(DAC_FRAME_W);
	localparam int WAIT_W = $clog2(WAIT_CYCLES + 1);

	typedef enum logic [1:0] {
		spi_idle,
		spi_lead,
		spi_shift,
		spi_wait
	} spi_state_t;

	spi_state_t state;
	logic [DAC_FRAME_W-1:0] frame;
	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	logic half_end;
	logic bit_end;
	logic last_bit;
	logic wait_end;

	assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign bit_end = (div_cnt == DIV_W'(2 * CLK_DIV - 1));
	assign last_bit = (bit_cnt == BIT_W'(DAC_FRAME_W - 1));
	assign wait_end = (wait_cnt == WAIT_W'(WAIT_CYCLES - 1));
	assign rdy_o = (state == spi_idle);
	// msb first
	assign sdi_o = frame[DAC_FRAME_W-1];

	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state <= spi_idle;
			frame <= '0;
			div_cnt <= '0;
			bit_cnt <= '0;
			wait_cnt <= '0;
			sync_o <= 1'b1;
			sclk_o <= 1'b0;
		end else begin
			case (state)
				spi_idle: begin
					if (wre_i) begin
						frame <= {{DAC_PAD_W{1'b0}}, code_i};
						state <= spi_lead;
					end
				end
				// sync drops one clock after accept
				spi_lead: begin
					sync_o <= 1'b0;
					div_cnt <= '0;
					bit_cnt <= '0;
					state <= spi_shift;
				end
				// sclk low first half, high second half
				spi_shift: begin
					if (bit_end) begin
						sclk_o <= 1'b0;
						div_cnt <= '0;
						if (last_bit) begin
							sync_o <= 1'b1;
							wait_cnt <= '0;
							state <= spi_wait;
						end else begin
							frame <= {frame[DAC_FRAME_W-2:0], 1'b0};
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
						if (half_end) begin
							sclk_o <= 1'b1;
						end
					end
				end
				// dac settle time before next frame
				default: begin
					if (wait_end) begin
						state <= spi_idle;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

//--- source/point_fifo.sv
`timescale 1ns/1ps

module point_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input	logic			wb_clk_i,
	input	logic			wb_rst_i,
	input	mu_meas_pkg::point_t	p1_i,
	input	mu_meas_pkg::point_t	p2_i,
	input	logic			p1_valid_i,
	input	logic			p2_valid_i,
	output	logic			p1_accept_o,
	output	logic			p2_accept_o,
	output	mu_meas_pkg::point_t	head_o,
	output	logic			n_empty_o,
	input	logic			pop_i
);
	import mu_meas_pkg::*;

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

	point_t mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0] count;
	logic full;
	logic wr_en;
	logic rd_en;
	point_t wr_data;

	// count never passes DEPTH so the top bit means full
	assign full = count[FIFO_DEPTH_LOG2];
	assign n_empty_o = (count != '0);
	// channel 1 wins, channel 2 waits a cycle
	assign p1_accept_o = p1_valid_i & ~full;
	assign p2_accept_o = p2_valid_i & ~p1_valid_i & ~full;
	assign wr_en = p1_accept_o | p2_accept_o;
	assign wr_data = p1_accept_o ? p1_i : p2_i;
	assign rd_en = pop_i & n_empty_o;
	assign head_o = mem[rd_ptr];

	always_ff @(posedge wb_clk_i) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge wb_clk_i, posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- source/measure_unit.sv
`timescale 1ns/1ps

module measure_unit #(
	parameter int CLK_DIV = 3,
	parameter int WAIT_CYCLES = 3,
	parameter mu_meas_pkg::delay_code_t DEFAULT_DELAY_DELTA = 10'd1,
	parameter mu_meas_pkg::threshold_t DEFAULT_THRESHOLD_DELTA = 16'd1,
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	// wishbone
	input	logic				wb_clk_i,
	input	logic				wb_rst_i,
	input	mu_regs_pkg::wb_data_t		wb_dat_i,
	input	mu_regs_pkg::wb_data_t		wb_adr_i,
	input	logic				wb_we_i,
	input	logic [mu_regs_pkg::WB_SEL_W-1:0]	wb_sel_i,
	input	logic				wb_cyc_i,
	input	logic				wb_stb_i,
	output	mu_regs_pkg::wb_data_t		wb_dat_o,
	output	logic				wb_ack_o,
	// comparators
	input	logic				cmp1_i,
	input	logic				cmp2_i,
	// dac links
	output	logic				dac1_sync_o,
	output	logic				dac1_sclk_o,
	output	logic				dac1_sdi_o,
	output	logic				dac2_sync_o,
	output	logic				dac2_sclk_o,
	output	logic				dac2_sdi_o,
	// delay lines
	output	mu_meas_pkg::delay_code_t	delay1_code_o,
	output	mu_meas_pkg::delay_code_t	delay2_code_o
);
	import mu_meas_pkg::*;

	logic [1:0] scan_busy;
	logic [1:0] dac_rdy;
	threshold_t dac1_code;
	threshold_t dac2_code;
	logic dac1_wre;
	logic dac2_wre;
	point_t point1;
	point_t point2;
	logic point1_valid;
	logic point2_valid;
	logic point1_accept;
	logic point2_accept;
	point_t fifo_head;
	logic fifo_n_empty;
	logic fifo_pop;

	mu_ctl_if ctl_bus ();

	////////////////////////////////////////////////////////////
	// input side
	////////////////////////////////////////////////////////////
	mu_wb_regs #(
		.DEFAULT_DELAY_DELTA		(DEFAULT_DELAY_DELTA),
		.DEFAULT_THRESHOLD_DELTA	(DEFAULT_THRESHOLD_DELTA)
	) regs_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.wb_dat_i	(wb_dat_i),
		.wb_adr_i	(wb_adr_i),
		.wb_we_i	(wb_we_i),
		.wb_sel_i	(wb_sel_i),
		.wb_cyc_i	(wb_cyc_i),
		.wb_stb_i	(wb_stb_i),
		.wb_dat_o	(wb_dat_o),
		.wb_ack_o	(wb_ack_o),
		.ctl		(ctl_bus.regs),
		.scan_busy_i	(scan_busy),
		.dac_rdy_i	(dac_rdy),
		.fifo_head_i	(fifo_head),
		.fifo_n_empty_i	(fifo_n_empty),
		.fifo_pop_o	(fifo_pop)
	);

	////////////////////////////////////////////////////////////
	// scan controllers, channel 0 feeds fifo port 1
	////////////////////////////////////////////////////////////
	threshold_scan #(.CHANNEL(1'b0)) scan1_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.ctl		(ctl_bus.scan),
		.cmp_i		(cmp1_i),
		.dac_code_o	(dac1_code),
		.dac_wre_o	(dac1_wre),
		.dac_rdy_i	(dac_rdy[0]),
		.delay_code_o	(delay1_code_o),
		.point_o	(point1),
		.point_valid_o	(point1_valid),
		.point_accept_i	(point1_accept),
		.busy_o		(scan_busy[0])
	);

	threshold_scan #(.CHANNEL(1'b1)) scan2_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.ctl		(ctl_bus.scan),
		.cmp_i		(cmp2_i),
		.dac_code_o	(dac2_code),
		.dac_wre_o	(dac2_wre),
		.dac_rdy_i	(dac_rdy[1]),
		.delay_code_o	(delay2_code_o),
		.point_o	(point2),
		.point_valid_o	(point2_valid),
		.point_accept_i	(point2_accept),
		.busy_o		(scan_busy[1])
	);

	////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////
	dac_spi_master #(.CLK_DIV(CLK_DIV), .WAIT_CYCLES(WAIT_CYCLES)) dac1_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.code_i		(dac1_code),
		.wre_i		(dac1_wre),
		.rdy_o		(dac_rdy[0]),
		.sync_o		(dac1_sync_o),
		.sclk_o		(dac1_sclk_o),
		.sdi_o		(dac1_sdi_o)
	);

	dac_spi_master #(.CLK_DIV(CLK_DIV), .WAIT_CYCLES(WAIT_CYCLES)) dac2_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.code_i		(dac2_code),
		.wre_i		(dac2_wre),
		.rdy_o		(dac_rdy[1]),
		.sync_o		(dac2_sync_o),
		.sclk_o		(dac2_sclk_o),
		.sdi_o		(dac2_sdi_o)
	);

	point_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) fifo_inst (
		.wb_clk_i	(wb_clk_i),
		.wb_rst_i	(wb_rst_i),
		.p1_i		(point1),
		.p2_i		(point2),
		.p1_valid_i	(point1_valid),
		.p2_valid_i	(point2_valid),
		.p1_accept_o	(point1_accept),
		.p2_accept_o	(point2_accept),
		.head_o		(fifo_head),
		.n_empty_o	(fifo_n_empty),
		.pop_i		(fifo_pop)
	);

endmodule

//--- bench/measure_unit_props.sv
`timescale 1ns/1ps

module measure_unit_props (
	input	logic	wb_clk_i,
	input	logic	wb_rst_i,
	input	logic	wb_cyc_i,
	input	logic	wb_stb_i,
	input	logic	wb_ack_o,
	input	logic	dac1_sync_o,
	input	logic	dac1_sclk_o,
	input	logic	dac2_sync_o,
	input	logic	dac2_sclk_o
);

	// ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("wishbone ack held for more than one cycle");

	// no ack without a request in the cycle before
	ack_after_request: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wishbone ack without cyc and stb");

	// serial clock parked low between frames
	dac1_sclk_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		dac1_sync_o |-> !dac1_sclk_o)
		else $error("dac1 sclk high while sync is high");

	dac2_sclk_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		dac2_sync_o |-> !dac2_sclk_o)
		else $error("dac2 sclk high while sync is high");

endmodule

bind measure_unit measure_unit_props props_inst (.*);

//--- bench/measure_unit_tb.sv
`timescale 1ns/1ps

module measure_unit_tb;
	import mu_regs_pkg::*;
	import mu_meas_pkg::*;

	// stored bits of the delta register
	localparam logic [31:0] DELTA_MASK = 32'h03ff_ffff;

	logic wb_clk_i;
	logic wb_rst_i;
	wb_data_t wb_dat_i;
	wb_data_t wb_adr_i;
	logic wb_we_i;
	logic [3:0] wb_sel_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	wb_data_t wb_dat_o;
	logic wb_ack_o;
	logic cmp1_i;
	logic cmp2_i;
	logic dac1_sync_o;
	logic dac1_sclk_o;
	logic dac1_sdi_o;
	logic dac2_sync_o;
	logic dac2_sclk_o;
	logic dac2_sdi_o;
	delay_code_t delay1_code_o;
	delay_code_t delay2_code_o;

	int checks = 0;
	int errors = 0;
	logic [31:0] lcg_state = 32'hf5a6;
	// comparator trip level per channel and delay code
	logic [15:0] level_tab [2][1024];
	logic [23:0] shreg [2];
	threshold_t dac_code [2];
	int frames [2] = '{0, 0};
	// compare process state
	point_t got_q [$];
	int next_delay [2];
	int seen [2];
	int exp_frames [2];
	int cur_dd = 1;
	int cur_td = 1;

	measure_unit dut (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #20 wb_clk_i = ~wb_clk_i;
	end

	////////////////////////////////////////////////////////////
	// dac frame decoders and comparator model
	////////////////////////////////////////////////////////////
	always @(posedge dac1_sclk_o) if (!dac1_sync_o) shreg[0] <= {shreg[0][22:0], dac1_sdi_o};
	always @(posedge dac2_sclk_o) if (!dac2_sync_o) shreg[1] <= {shreg[1][22:0], dac2_sdi_o};

	// code is complete when sync rises
	always @(posedge dac1_sync_o) begin
		dac_code[0] <= shreg[0][15:0];
		frames[0] <= frames[0] + 1;
	end

	always @(posedge dac2_sync_o) begin
		dac_code[1] <= shreg[1][15:0];
		frames[1] <= frames[1] + 1;
	end

	// comparator high while dac code is under the trip level
	always @(negedge wb_clk_i) begin
		cmp1_i <= (dac_code[0] < level_tab[0][delay1_code_o]);
		cmp2_i <= (dac_code[1] < level_tab[1][delay2_code_o]);
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// smallest delta multiple at or above level, capped at last reachable step
	function automatic int expected_threshold(input int level, input int delta);
		int cap;
		int thr;
		cap = (65535 / delta) * delta;
		thr = ((level + delta - 1) / delta) * delta;
		return (thr > cap) ? cap : thr;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic fill_levels(input int base, input int mask);
		for (int ch = 0; ch < 2; ch++) begin
			for (int d = 0; d < 1024; d++) begin
				lcg_state = lcg_next(lcg_state);
				level_tab[ch][d] = 16'(base + (lcg_state[23:8] & mask));
			end
		end
	endtask

	task automatic bus_cycle(input logic we, input reg_addr_t addr, input wb_data_t data,
		input logic [3:0] sel, output wb_data_t q);
		int n;
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = {27'b0, addr, 2'b00};
		wb_dat_i = data;
		wb_sel_i = sel;
		n = 0;
		do begin
			@(negedge wb_clk_i);
			n++;
		end while (!wb_ack_o && n < 16);
		if (!wb_ack_o) report_failure($sformatf("no ack from register %0d", addr));
		q = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic bus_write(input reg_addr_t addr, input wb_data_t data, input logic [3:0] sel);
		wb_data_t q;
		bus_cycle(1'b1, addr, data, sel, q);
	endtask

	task automatic bus_read(input reg_addr_t addr, output wb_data_t q);
		bus_cycle(1'b0, addr, '0, 4'hf, q);
	endtask

	task automatic test_done(input int num, input string name, input int start_errors);
		if (errors == start_errors) $display("test %0d %s: ok", num, name);
		else $display("test %0d %s: %0d errors", num, name, errors - start_errors);
	endtask

	// scan with given steps, popping points until run drops
	task automatic run_scan(input int dd, input int td, input bit hold_fifo, input bit direct);
		wb_data_t q;
		int n;
		int stable;
		int last;
		int frame_base [2];
		bit finished;
		bit empty;
		bus_write(REG_DELTA, (32'(dd) << DLY_DELTA_LSB) | 32'(td), 4'hf);
		cur_dd = dd;
		cur_td = td;
		for (int ch = 0; ch < 2; ch++) begin
			next_delay[ch] = 0;
			seen[ch] = 0;
			exp_frames[ch] = 0;
			frame_base[ch] = frames[ch];
		end
		bus_write(REG_CTL, 32'h1, 4'hf);
		// must not reach the dacs while run is set
		if (direct) bus_write(REG_THRESHOLD, 32'h0000_beef, 4'b0011);
		if (hold_fifo) begin
			stable = 0;
			last = frames[0] + frames[1];
			for (n = 0; n < 200000 && stable < 1000; n++) begin
				@(negedge wb_clk_i);
				if (frames[0] + frames[1] == last) stable++;
				else begin
					stable = 0;
					last = frames[0] + frames[1];
				end
			end
			if (stable < 1000) report_failure("scan never stalled on a full FIFO");
			bus_read(REG_CTL, q);
			check_value("busy with full FIFO", q[CTL_BUSY_BIT], 1'b1);
		end
		finished = 0;
		for (n = 0; n < 100000 && !finished; n++) begin
			bus_read(REG_POINT, q);
			if (q[POINT_VALID_BIT]) got_q.push_back(point_t'(q[27:1]));
			else begin
				bus_read(REG_CTL, q);
				if (!q[CTL_RUN_BIT]) finished = 1;
			end
		end
		if (!finished) report_failure("scan did not finish in time");
		empty = 0;
		for (n = 0; n < 64 && !empty; n++) begin
			bus_read(REG_POINT, q);
			if (q[POINT_VALID_BIT]) got_q.push_back(point_t'(q[27:1]));
			else empty = 1;
		end
		for (n = 0; n < 10 && got_q.size() > 0; n++) @(negedge wb_clk_i);
		if (got_q.size() > 0) report_failure("compare process did not take all points");
		for (int ch = 0; ch < 2; ch++) begin
			check_value($sformatf("ch%0d point count", ch), seen[ch], 1023 / dd + 1);
			check_value($sformatf("ch%0d frame count", ch), frames[ch] - frame_base[ch],
				exp_frames[ch]);
		end
		// delay line stays at the last scanned code
		check_value("delay1_code_o at end", delay1_code_o, (1023 / dd) * dd);
		check_value("delay2_code_o at end", delay2_code_o, (1023 / dd) * dd);
		bus_read(REG_CTL, q);
		check_value("run and busy after scan", q[1:0], 2'b00);
	endtask

	////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////
	initial begin : compare_points
		point_t p;
		int ch;
		int exp_thr;
		forever begin
			@(negedge wb_clk_i);
			while (got_q.size() > 0) begin
				p = got_q.pop_front();
				ch = p.channel;
				if (next_delay[ch] > 1023) begin
					report_failure($sformatf("extra point on channel %0d", ch));
				end else begin
					exp_thr = expected_threshold(level_tab[ch][next_delay[ch]], cur_td);
					check_value($sformatf("ch%0d delay code", ch), p.delay_code, next_delay[ch]);
					check_value($sformatf("ch%0d threshold", ch), p.threshold, exp_thr);
					// frames for steps 0 up to the point
					exp_frames[ch] += exp_thr / cur_td + 1;
					next_delay[ch] += cur_dd;
					seen[ch]++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial begin : main_flow
		wb_data_t q;
		logic [31:0] exp_word;
		int start;
		int n;
		int fb [2];
		wb_rst_i = 1'b1;
		wb_dat_i = '0;
		wb_adr_i = '0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'h0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		cmp1_i = 1'b0;
		cmp2_i = 1'b0;
		repeat (8) @(negedge wb_clk_i);
		wb_rst_i = 1'b0;

		// defaults and byte lanes
		start = errors;
		bus_read(REG_DELTA, q);
		exp_word = 32'h0001_0001;
		check_value("REG_DELTA after reset", q, exp_word);
		bus_write(REG_DELTA, 32'h5a5a_a5a5, 4'b0010);
		exp_word = merge_bytes(exp_word, 32'h5a5a_a5a5, 4'b0010) & DELTA_MASK;
		bus_read(REG_DELTA, q);
		check_value("REG_DELTA byte 1 write", q, exp_word);
		bus_write(REG_DELTA, 32'h0080_0000, 4'b0100);
		exp_word = merge_bytes(exp_word, 32'h0080_0000, 4'b0100) & DELTA_MASK;
		bus_read(REG_DELTA, q);
		check_value("REG_DELTA byte 2 write", q, exp_word);
		test_done(1, "register defaults and byte select", start);

		// direct write reaches both dacs
		start = errors;
		fb[0] = frames[0];
		fb[1] = frames[1];
		bus_write(REG_THRESHOLD, 32'h0000_3c5a, 4'b0011);
		for (n = 0; n < 2000 && !(frames[0] > fb[0] && frames[1] > fb[1]); n++) begin
			@(negedge wb_clk_i);
		end
		check_value("dac1 frames", frames[0] - fb[0], 1);
		check_value("dac2 frames", frames[1] - fb[1], 1);
		check_value("dac1 code", dac_code[0], 16'h3c5a);
		check_value("dac2 code", dac_code[1], 16'h3c5a);
		n = 0;
		do begin
			bus_read(REG_THRESHOLD, q);
			n++;
		end while (q[1:0] != 2'b11 && n < 50);
		check_value("dac ready bits", q[1:0], 2'b11);
		test_done(2, "direct threshold while idle", start);

		start = errors;
		fill_levels(0, 16'h001f);
		run_scan(128, 1, 1'b0, 1'b0);
		test_done(3, "scan with unit threshold step", start);

		// levels partly above the top reachable step
		start = errors;
		fill_levels(16'hc000, 16'h3fff);
		run_scan(128, 16'h3000, 1'b0, 1'b0);
		test_done(4, "capped threshold", start);

		start = errors;
		fill_levels(0, 16'h0007);
		run_scan(64, 1, 1'b1, 1'b0);
		test_done(5, "full FIFO back-pressure", start);

		start = errors;
		fill_levels(0, 16'h0003);
		run_scan(256, 1, 1'b0, 1'b1);
		bus_read(REG_POINT, q);
		check_value("empty point valid", q[POINT_VALID_BIT], 1'b0);
		test_done(6, "direct write during scan and empty pop", start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- project.f
source/mu_regs_pkg.sv
source/mu_meas_pkg.sv
source/mu_ctl_if.sv
source/mu_wb_regs.sv
source/threshold_scan.sv
source/dac_spi_master.sv
source/point_fifo.sv
source/measure_unit.sv
bench/measure_unit_props.sv
bench/measure_unit_tb.sv
